/* Bender.yml */
package:
  name: vrf

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vrf_pkg.sv
      - vrf_apb_port.sv
      - vrf_arbiter.sv
      - vrf_banks.sv
      - rv32v_read_xbar.sv
      - vrf_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vrf_properties.sv
      - tb_vrf.sv

/* list.f */
+incdir+.
vrf_pkg.sv
vrf_apb_port.sv
vrf_arbiter.sv
vrf_banks.sv
rv32v_read_xbar.sv
vrf_top.sv
vrf_properties.sv
tb_vrf.sv

/* rv32v_read_xbar.sv */
// vector read crossbar
// spreads the bank words of one register over four lanes by element width

`timescale 1ns/1ns

module rv32v_read_xbar import vrf_pkg::*; (
    input  word_t [3:0]    bank_dat,
    input  vrf_xbar_ctrl_t xbar_ctrl,
    output word_t [3:0]    out_dat
);

    logic [1:0] next_off;
    word_t      base_w;
    word_t      next_w;

    // halfword lanes 2 and 3 come from the following bank, wrapping at 4
    assign next_off = xbar_ctrl.bank_offset + 2'd1;
    assign base_w   = bank_dat[xbar_ctrl.bank_offset];
    assign next_w   = bank_dat[next_off];

    // halfword to word
    function automatic word_t ext16(input logic [15:0] h, input logic s);
        return s ? {{16{h[15]}}, h} : {16'b0, h};
    endfunction

    // byte to word
    function automatic word_t ext8(input logic [7:0] b, input logic s);
        return s ? {{24{b[7]}}, b} : {24'b0, b};
    endfunction

    // ************************************************************
    // lane mapping
    // ************************************************************
    always_comb begin
        case (xbar_ctrl.eew)
            // straight through, lane i is bank i
            BYTE_4: out_dat = bank_dat;
            BYTE_2: begin
                out_dat[0] = ext16(base_w[15:0], xbar_ctrl.sign_ext);
                out_dat[1] = ext16(base_w[31:16], xbar_ctrl.sign_ext);
                out_dat[2] = ext16(next_w[15:0], xbar_ctrl.sign_ext);
                out_dat[3] = ext16(next_w[31:16], xbar_ctrl.sign_ext);
            end
            // BYTE_1 and the unused code
            default: begin
                // byte k of the offset bank, byte 3 is bits 31:24
                for (int k = 0; k < 4; k++) begin
                    out_dat[k] = ext8(base_w[8*k +: 8], xbar_ctrl.sign_ext);
                end
            end
        endcase
    end

endmodule

/* tb_vrf.sv */
// vector register file testbench
// table driven apb traffic on both ports, checked against a model of the lane rules

`timescale 1ns/1ns
`include "vrf_macros.svh"

module tb_vrf;

    localparam int TBL_N     = 31;
    localparam int CYC_LIMIT = 16 + TBL_N * 12 + 200;

    // inputs of one apb port
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`VRF_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_in_t;

    // one table entry, dual entries use port 0 on reg_idx and port 1 on reg_idx + 1
    typedef struct packed {
        logic        dual;
        logic        port;
        logic        write;
        logic [4:0]  reg_idx;
        logic [1:0]  eew;
        logic [1:0]  bank;
        logic        sign_ext;
        logic [1:0]  lane;
        logic [31:0] wdata;
        logic [31:0] exp_dat;
    } stim_t;

    logic            clk;
    logic            reset;
    apb_in_t [1:0]   apb;
    logic [1:0][31:0] prdata;
    logic [1:0]      pready;
    logic [1:0]      pslverr;

    logic [31:0] model [`VRF_NUM_REGS][4];
    stim_t       tbl [TBL_N];
    logic [31:0] lcg_state;
    // expected arbiter priority, 1 favours port 1
    logic        prio;
    int          cycles;
    int          errors;
    int          checks;
    logic [31:0] got_dat [2];
    logic        got_err [2];
    int          got_wait [2];

    vrf_top dut0 (
        .clk(clk), .reset(reset),
        .psel_0(apb[0].psel), .penable_0(apb[0].penable), .pwrite_0(apb[0].pwrite),
        .paddr_0(apb[0].paddr), .pwdata_0(apb[0].pwdata),
        .prdata_0(prdata[0]), .pready_0(pready[0]), .pslverr_0(pslverr[0]),
        .psel_1(apb[1].psel), .penable_1(apb[1].penable), .pwrite_1(apb[1].pwrite),
        .paddr_1(apb[1].paddr), .pwdata_1(apb[1].pwdata),
        .prdata_1(prdata[1]), .pready_1(pready[1]), .pslverr_1(pslverr[1])
    );

    // ************************************************************
    // helpers
    // ************************************************************
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // lane value from the crossbar rules, word view returns the bank word
    function automatic logic [31:0] read_model(input logic [4:0] r, input logic [1:0] eew,
                                               input logic [1:0] off, input logic sgn,
                                               input logic [1:0] lane);
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        if (eew == 2'd0) return model[r][off];
        if (eew == 2'd1) begin
            // lanes 2 and 3 come from the next bank, wrapping
            w = model[r][(off + lane[1]) % 4];
            h = lane[0] ? w[31:16] : w[15:0];
            return sgn ? {{16{h[15]}}, h} : {16'b0, h};
        end
        w = model[r][off];
        b = w[8*lane +: 8];
        return sgn ? {{24{b[7]}}, b} : {24'b0, b};
    endfunction

    function automatic logic [15:0] make_addr(input stim_t s, input logic [4:0] r);
        if (s.eew == 2'd0) return {5'b0, 2'b00, r, s.bank, 2'b00};
        return {2'b0, s.lane, s.sign_ext, s.eew, r, s.bank, 2'b00};
    endfunction

    function automatic stim_t mk(input logic dual, input logic port, input logic write,
                                 input logic [4:0] r, input logic [1:0] eew,
                                 input logic [1:0] bank, input logic sgn,
                                 input logic [1:0] lane);
        stim_t s;
        s.dual     = dual;
        s.port     = port;
        s.write    = write;
        s.reg_idx  = r;
        s.eew      = eew;
        s.bank     = bank;
        s.sign_ext = sgn;
        s.lane     = lane;
        // refused writes carry a value the banks must never see
        s.wdata    = (eew == 2'd0) ? model[r][bank] : ~model[r][bank];
        s.exp_dat  = read_model(r, eew, bank, sgn, lane);
        return s;
    endfunction

    task automatic report_mismatch(input string what, input int p, input logic [15:0] addr,
                                   input logic [31:0] exp_v, input logic [31:0] got_v);
        $display("[ERROR] %0t port %0d addr %h %s: expected %h, got %h",
                 $time, p, addr, what, exp_v, got_v);
        errors++;
    endtask

    // ************************************************************
    // apb driver, both ports in lockstep
    // ************************************************************
    task automatic drive_xfer(input logic [1:0] act, input apb_in_t [1:0] nxt);
        logic [1:0] busy;
        logic [1:0] fin;
        int         cnt;
        busy = act;
        fin  = 2'b00;
        cnt  = 0;
        // setup phase
        @(negedge clk);
        apb = nxt;
        @(negedge clk);
        for (int p = 0; p < 2; p++) apb[p].penable = act[p];
        // count access edges until pready
        while (busy != 2'b00) begin
            @(negedge clk);
            cnt++;
            for (int p = 0; p < 2; p++) begin
                if (fin[p]) begin
                    apb[p] = '0;
                    fin[p] = 1'b0;
                end
                if (busy[p] && pready[p]) begin
                    got_dat[p]  = prdata[p];
                    got_err[p]  = pslverr[p];
                    got_wait[p] = cnt;
                    busy[p]     = 1'b0;
                    fin[p]      = 1'b1;
                end
            end
        end
        @(negedge clk);
        apb = '0;
    endtask

    task automatic run_entry(input int idx);
        stim_t         s;
        apb_in_t [1:0] nxt;
        logic [1:0]    act;
        logic [4:0]    r [2];
        logic [31:0]   exp_dat [2];
        int            exp_wait [2];
        logic          exp_err;
        logic          first;
        s       = tbl[idx];
        nxt     = '0;
        act     = s.dual ? 2'b11 : (2'b01 << s.port);
        r[0]    = s.reg_idx;
        r[1]    = s.dual ? s.reg_idx + 5'd1 : s.reg_idx;
        exp_err = s.write && (s.eew != 2'd0);
        // the favoured port goes first, the other waits one more cycle
        first   = s.dual ? prio : s.port;
        for (int p = 0; p < 2; p++) begin
            nxt[p].psel   = act[p];
            nxt[p].pwrite = s.write;
            nxt[p].paddr  = make_addr(s, r[p]);
            nxt[p].pwdata = (p == 1 && s.dual) ? model[r[1]][s.bank] : s.wdata;
            exp_dat[p]    = (p == 1 && s.dual) ?
                            read_model(r[1], s.eew, s.bank, s.sign_ext, s.lane) : s.exp_dat;
            exp_wait[p]   = (s.dual && p != first) ? 2 : 1;
        end
        drive_xfer(act, nxt);
        // a single grant hands priority to the other port, a dual pair leaves it
        if (!s.dual && !exp_err) prio = ~s.port;
        for (int p = 0; p < 2; p++) begin
            if (act[p]) begin
                checks++;
                if (got_wait[p] != exp_wait[p])
                    report_mismatch("wait states", p, nxt[p].paddr, exp_wait[p], got_wait[p]);
                if (got_err[p] !== exp_err)
                    report_mismatch("pslverr", p, nxt[p].paddr, exp_err, got_err[p]);
                if (!s.write && got_dat[p] !== exp_dat[p])
                    report_mismatch("prdata", p, nxt[p].paddr, exp_dat[p], got_dat[p]);
            end
        end
    endtask

    // ************************************************************
    // clock, timeout and main sequence
    // ************************************************************
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYC_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        apb       = '0;
        errors    = 0;
        checks    = 0;
        prio      = 1'b0;
        lcg_state = 32'h5ece_1c55;
        for (int r = 0; r < `VRF_NUM_REGS; r++) begin
            for (int b = 0; b < 4; b++) begin
                lcg_state   = lcg_next(lcg_state);
                model[r][b] = lcg_state;
            end
        end
        // register 17 is negative in every byte and halfword
        for (int b = 0; b < 4; b++) model[17][b] |= 32'h8080_8080;

        // word writes, dual entries fill registers 4 and 5 together
        tbl[0]  = mk(1, 0, 1, 5'd4,  2'd0, 2'd0, 0, 2'd0);
        tbl[1]  = mk(1, 0, 1, 5'd4,  2'd0, 2'd1, 0, 2'd0);
        tbl[2]  = mk(1, 0, 1, 5'd4,  2'd0, 2'd2, 0, 2'd0);
        tbl[3]  = mk(1, 0, 1, 5'd4,  2'd0, 2'd3, 0, 2'd0);
        tbl[4]  = mk(0, 0, 1, 5'd17, 2'd0, 2'd0, 0, 2'd0);
        tbl[5]  = mk(0, 1, 1, 5'd17, 2'd0, 2'd1, 0, 2'd0);
        tbl[6]  = mk(0, 0, 1, 5'd17, 2'd0, 2'd2, 0, 2'd0);
        tbl[7]  = mk(0, 1, 1, 5'd17, 2'd0, 2'd3, 0, 2'd0);
        // word view read back
        tbl[8]  = mk(0, 0, 0, 5'd4,  2'd0, 2'd2, 0, 2'd0);
        tbl[9]  = mk(0, 1, 0, 5'd17, 2'd0, 2'd3, 0, 2'd0);
        // halfwords, offsets 0 to 3 with the wrap to bank 0
        tbl[10] = mk(0, 1, 0, 5'd17, 2'd1, 2'd0, 0, 2'd1);
        tbl[11] = mk(0, 0, 0, 5'd17, 2'd1, 2'd1, 1, 2'd2);
        tbl[12] = mk(0, 1, 0, 5'd4,  2'd1, 2'd2, 0, 2'd3);
        tbl[13] = mk(0, 0, 0, 5'd4,  2'd1, 2'd3, 1, 2'd2);
        tbl[14] = mk(0, 1, 0, 5'd5,  2'd1, 2'd3, 0, 2'd3);
        tbl[15] = mk(0, 0, 0, 5'd17, 2'd1, 2'd3, 1, 2'd3);
        // bytes of the offset bank
        tbl[16] = mk(0, 1, 0, 5'd17, 2'd2, 2'd2, 1, 2'd3);
        tbl[17] = mk(0, 0, 0, 5'd17, 2'd2, 2'd0, 0, 2'd3);
        tbl[18] = mk(0, 1, 0, 5'd4,  2'd2, 2'd1, 1, 2'd0);
        tbl[19] = mk(0, 0, 0, 5'd5,  2'd2, 2'd3, 0, 2'd1);
        // dual reads, singles in between move the priority
        tbl[20] = mk(1, 0, 0, 5'd4,  2'd0, 2'd1, 0, 2'd0);
        tbl[21] = mk(0, 1, 0, 5'd17, 2'd0, 2'd0, 0, 2'd0);
        tbl[22] = mk(1, 0, 0, 5'd4,  2'd1, 2'd3, 1, 2'd2);
        tbl[23] = mk(0, 0, 0, 5'd5,  2'd2, 2'd2, 1, 2'd1);
        tbl[24] = mk(1, 0, 0, 5'd4,  2'd2, 2'd2, 0, 2'd3);
        tbl[25] = mk(0, 1, 0, 5'd17, 2'd1, 2'd2, 0, 2'd0);
        tbl[26] = mk(1, 0, 0, 5'd4,  2'd1, 2'd0, 1, 2'd1);
        // element writes are refused, target word read back afterwards
        tbl[27] = mk(0, 0, 1, 5'd17, 2'd1, 2'd1, 0, 2'd0);
        tbl[28] = mk(0, 1, 0, 5'd17, 2'd0, 2'd1, 0, 2'd0);
        tbl[29] = mk(0, 1, 1, 5'd4,  2'd2, 2'd2, 0, 2'd0);
        tbl[30] = mk(0, 0, 0, 5'd4,  2'd0, 2'd2, 0, 2'd0);

        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checks++;
        if (pready !== 2'b00 || pslverr !== 2'b00) begin
            $display("[ERROR] %0t outputs not idle after reset: pready %b pslverr %b",
                     $time, pready, pslverr);
            errors++;
        end

        for (int i = 0; i < TBL_N; i++) run_entry(i);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vrf_apb_port.sv */
// vrf apb slave port
// decodes the address, requests the banks and completes the transfer

`timescale 1ns/1ns
`include "vrf_macros.svh"

module vrf_apb_port import vrf_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`VRF_ADDR_W-1:0] paddr,
    input  word_t                  pwdata,
    output word_t                  prdata,
    output logic                   pready,
    output logic                   pslverr,
    output vrf_req_t               req,
    input  logic                   grant,
    input  logic                   rsp_valid,
    input  word_t [3:0]            lane_dat
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RSP} state_e;

    state_e     state_q;
    logic       err_q;
    logic [1:0] lane_q;
    vrf_addr_u  addr;
    logic       access;
    logic       refuse;
    logic       word_view;

    assign addr      = paddr;
    assign access    = psel & penable;
    assign word_view = (addr.word.eew == BYTE_4);
    // element writes are not supported
    assign refuse    = pwrite & ~word_view;

    // ************************************************************
    // request towards the arbiter
    // ************************************************************
    always_comb begin
        req.valid    = access & ~refuse & (state_q != ST_RSP);
        req.write    = pwrite;
        req.reg_idx  = addr.word.reg_idx;
        req.eew      = addr.word.eew;
        // offset lives in the same bits as the word bank
        req.bank     = addr.word.bank;
        req.sign_ext = word_view ? 1'b0 : addr.elem.sign_ext;
        req.wdata    = pwdata;
    end

    // ************************************************************
    // transfer state
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (access) begin
                    if (refuse) begin
                        // answer locally, banks untouched
                        state_q <= ST_RSP;
                        err_q   <= 1'b1;
                    end else if (grant) begin
                        state_q <= ST_RSP;
                    end else begin
                        state_q <= ST_REQ;
                    end
                end
                // held until the arbiter picks this port
                ST_REQ: if (grant) state_q <= ST_RSP;
                default: if (pready) begin
                    state_q <= ST_IDLE;
                    err_q   <= 1'b0;
                end
            endcase
        end
    end

    // lane to return, word view maps lane to bank
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && access) begin
            lane_q <= word_view ? addr.word.bank : addr.elem.lane;
        end
    end

    // read data arrives one cycle after the grant
    assign pready  = (state_q == ST_RSP) & (rsp_valid | err_q);
    assign pslverr = (state_q == ST_RSP) & err_q;
    assign prdata  = rsp_valid ? lane_dat[lane_q] : '0;

endmodule

/* vrf_arbiter.sv */
// round-robin arbiter between the apb ports
// grants one request per cycle and tracks the owner of the next response

`timescale 1ns/1ns
`include "vrf_macros.svh"

module vrf_arbiter import vrf_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  vrf_req_t [`VRF_NUM_PORTS-1:0]   req,
    output logic     [`VRF_NUM_PORTS-1:0]   grant,
    output vrf_req_t                        bank_req,
    output logic     [`VRF_NUM_PORTS-1:0]   rsp_owner
);

    // 0 favours port 0, 1 favours port 1
    logic prio_q;

    // ************************************************************
    // grant, combinational
    // ************************************************************
    always_comb begin
        grant = '0;
        if (!prio_q) begin
            if (req[0].valid) begin
                grant[0] = 1'b1;
            end else if (req[1].valid) begin
                grant[1] = 1'b1;
            end
        end else begin
            if (req[1].valid) begin
                grant[1] = 1'b1;
            end else if (req[0].valid) begin
                grant[0] = 1'b1;
            end
        end
    end

    // forward the winner, valid only when someone won
    always_comb begin
        bank_req       = grant[1] ? req[1] : req[0];
        bank_req.valid = |grant;
    end

    // ************************************************************
    // priority and response owner
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_q    <= 1'b0;
            rsp_owner <= '0;
        end else begin
            // owner lines up with the registered bank data
            rsp_owner <= grant;
            // priority moves to the port not just served
            if (|grant) prio_q <= grant[0];
        end
    end

endmodule

/* vrf_banks.sv */
// vector register banks
// four word-wide memories, one word of each register per bank

`timescale 1ns/1ns
`include "vrf_macros.svh"

module vrf_banks import vrf_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  vrf_req_t       bank_req,
    output word_t [3:0]    bank_dat,
    output vrf_xbar_ctrl_t xbar_ctrl
);

    // bank by register index
    word_t mem [4][`VRF_NUM_REGS];

    logic do_wr;
    logic do_rd;

    assign do_wr = bank_req.valid & bank_req.write;
    assign do_rd = bank_req.valid & ~bank_req.write;

    // ************************************************************
    // memory write and registered read
    // ************************************************************
    always_ff @(posedge clk) begin
        // full word into the named bank
        if (do_wr) begin
            mem[bank_req.bank][bank_req.reg_idx] <= bank_req.wdata;
        end
        // all four banks at once, the crossbar picks later
        if (do_rd) begin
            for (int b = 0; b < 4; b++) begin
                bank_dat[b] <= mem[b][bank_req.reg_idx];
            end
        end
    end

    // controls travel alongside the read words
    always_ff @(posedge clk) begin
        if (reset) begin
            xbar_ctrl <= '0;
        end else if (do_rd) begin
            xbar_ctrl.eew         <= bank_req.eew;
            xbar_ctrl.bank_offset <= bank_req.bank;
            xbar_ctrl.sign_ext    <= bank_req.sign_ext;
        end
    end

endmodule

/* vrf_macros.svh */
// vector register file sizes
// fixed geometry shared by the package and the RTL

`ifndef VRF_MACROS_SVH
`define VRF_MACROS_SVH

// number of vector registers, one word per bank each
`define VRF_NUM_REGS 32

// register index width, log2 of the register count
`define VRF_REG_IDX_W 5

// apb address width on both slave ports
`define VRF_ADDR_W 16

// peer apb ports sharing the banks
`define VRF_NUM_PORTS 2

`endif

/* vrf_pkg.sv */
// vector register file types
// element width, apb address views, bank request and crossbar controls

`include "vrf_macros.svh"

package vrf_pkg;

    // one bank word
    typedef logic [31:0] word_t;

    // element width, value 3 behaves as BYTE_1
    typedef enum logic [1:0] {
        BYTE_4 = 2'd0,
        BYTE_2 = 2'd1,
        BYTE_1 = 2'd2
    } eew_e;

    // word view, used when eew is BYTE_4
    typedef struct packed {
        logic [4:0]                unused;
        eew_e                      eew;
        logic [`VRF_REG_IDX_W-1:0] reg_idx;
        logic [1:0]                bank;
        logic [1:0]                align;
    } vrf_addr_word_t;

    // element view, used for BYTE_2 and BYTE_1
    typedef struct packed {
        logic [1:0]                unused;
        logic [1:0]                lane;
        logic                      sign_ext;
        eew_e                      eew;
        logic [`VRF_REG_IDX_W-1:0] reg_idx;
        logic [1:0]                bank_offset;
        logic [1:0]                align;
    } vrf_addr_elem_t;

    // both views share eew in bits 10:9
    typedef union packed {
        vrf_addr_word_t word;
        vrf_addr_elem_t elem;
    } vrf_addr_u;

    // bank request, bank doubles as offset on element reads
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`VRF_REG_IDX_W-1:0] reg_idx;
        logic [1:0]                bank;
        eew_e                      eew;
        logic                      sign_ext;
        word_t                     wdata;
    } vrf_req_t;

    // crossbar controls held with the read data
    typedef struct packed {
        eew_e       eew;
        logic [1:0] bank_offset;
        logic       sign_ext;
    } vrf_xbar_ctrl_t;

endpackage

/* vrf_properties.sv */
// apb port and arbiter assertions
// bound into the register file top

`timescale 1ns/1ns

module vrf_properties (
    input logic       clk,
    input logic       reset,
    input logic [1:0] psel,
    input logic [1:0] penable,
    input logic [1:0] pwrite,
    input logic [1:0] pready,
    input logic [1:0] pslverr,
    input logic [1:0] grant
);

    // ************************************************************
    // per port apb rules
    // ************************************************************
    for (genvar p = 0; p < 2; p++) begin : g_port
        // ready only inside an access phase
        a_ready_access: assert property (@(posedge clk) disable iff (reset)
            pready[p] |-> (psel[p] && penable[p]))
            else $error("pready outside an access phase on port %0d", p);

        // error only together with ready, and only for a refused write
        a_err_ready: assert property (@(posedge clk) disable iff (reset)
            pslverr[p] |-> (pready[p] && pwrite[p]))
            else $error("pslverr without pready or on a read on port %0d", p);

        // one cycle per response
        a_ready_pulse: assert property (@(posedge clk) disable iff (reset)
            pready[p] |=> !pready[p])
            else $error("pready held longer than one cycle on port %0d", p);

        // at most one port wins the banks, the winner answers next cycle
        a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
            grant[p] |-> $onehot0(grant) ##1 pready[p])
            else $error("grant on port %0d not one-hot or not answered: %b", p, grant);
    end

endmodule

bind vrf_top vrf_properties u_props (
    .clk(clk), .reset(reset),
    .psel({psel_1, psel_0}), .penable({penable_1, penable_0}),
    .pwrite({pwrite_1, pwrite_0}),
    .pready({pready_1, pready_0}), .pslverr({pslverr_1, pslverr_0}),
    .grant(grant)
);

/* vrf_top.sv */
// vector register file top
// two apb slave ports sharing four banks through a round-robin arbiter

`timescale 1ns/1ns
`include "vrf_macros.svh"

module vrf_top import vrf_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    // port 0
    input  logic                   psel_0,
    input  logic                   penable_0,
    input  logic                   pwrite_0,
    input  logic [`VRF_ADDR_W-1:0] paddr_0,
    input  word_t                  pwdata_0,
    output word_t                  prdata_0,
    output logic                   pready_0,
    output logic                   pslverr_0,
    // port 1
    input  logic                   psel_1,
    input  logic                   penable_1,
    input  logic                   pwrite_1,
    input  logic [`VRF_ADDR_W-1:0] paddr_1,
    input  word_t                  pwdata_1,
    output word_t                  prdata_1,
    output logic                   pready_1,
    output logic                   pslverr_1
);

    vrf_req_t [`VRF_NUM_PORTS-1:0] port_req;
    logic     [`VRF_NUM_PORTS-1:0] grant;
    logic     [`VRF_NUM_PORTS-1:0] rsp_owner;
    vrf_req_t                      bank_req;
    vrf_xbar_ctrl_t                xbar_ctrl;
    word_t    [3:0]                bank_dat;
    // lane data is shared, rsp_owner tells each port whether it is theirs
    word_t    [3:0]                lane_dat;

    // ************************************************************
    // apb ports
    // ************************************************************
    vrf_apb_port u_port0 (
        .clk(clk), .reset(reset),
        .psel(psel_0), .penable(penable_0), .pwrite(pwrite_0),
        .paddr(paddr_0), .pwdata(pwdata_0),
        .prdata(prdata_0), .pready(pready_0), .pslverr(pslverr_0),
        .req(port_req[0]), .grant(grant[0]),
        .rsp_valid(rsp_owner[0]), .lane_dat(lane_dat)
    );

    vrf_apb_port u_port1 (
        .clk(clk), .reset(reset),
        .psel(psel_1), .penable(penable_1), .pwrite(pwrite_1),
        .paddr(paddr_1), .pwdata(pwdata_1),
        .prdata(prdata_1), .pready(pready_1), .pslverr(pslverr_1),
        .req(port_req[1]), .grant(grant[1]),
        .rsp_valid(rsp_owner[1]), .lane_dat(lane_dat)
    );

    // ************************************************************
    // shared datapath
    // ************************************************************
    vrf_arbiter u_arb (
        .clk(clk), .reset(reset), .req(port_req), .grant(grant),
        .bank_req(bank_req), .rsp_owner(rsp_owner)
    );

    vrf_banks u_banks (
        .clk(clk), .reset(reset), .bank_req(bank_req),
        .bank_dat(bank_dat), .xbar_ctrl(xbar_ctrl)
    );

    rv32v_read_xbar u_xbar (
        .bank_dat(bank_dat), .xbar_ctrl(xbar_ctrl), .out_dat(lane_dat)
    );

endmodule
